// ==== source/gemac_rx_pkg.sv ====
`default_nettype none

package gemac_rx_pkg;

   // GMII framing bytes.
   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0] SFD_BYTE      = 8'hD5;

   // fixed destination addresses.
   localparam logic [47:0] BCAST_ADDR = 48'hFFFF_FFFF_FFFF;
   localparam logic [47:0] PAUSE_ADDR = 48'h0180_C200_0001;

   // MAC control frame fields.
   localparam logic [15:0] PAUSE_TYPE    = 16'h8808;
   localparam logic [15:0] PAUSE_OPCODE  = 16'h0001;
   localparam logic [15:0] MIN_FRAME_LEN = 16'd64;   // dest through fcs.

   // reflected polynomial; residue is in msb-first bit order.
   localparam logic [31:0] CRC_POLY    = 32'hEDB8_8320;
   localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;

   // user data lags the registered stream by this many cycles.
   localparam int RX_DELAY = 7;

   typedef enum logic [3:0] {
      RX_IDLE,
      RX_PREAMBLE,
      RX_ADDR,
      RX_FRAME,
      RX_PAUSE_TYPE,
      RX_PAUSE_OPCODE,
      RX_PAUSE_QUANTA,
      RX_PAUSE_WAIT_CRC,
      RX_GOODFRAME,
      RX_DO_PAUSE,
      RX_ERROR,
      RX_DROP
   } rx_state_t;

endpackage

`default_nettype wire

// ==== source/rx_byte_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface rx_byte_if;

   logic       dv;      // registered gmii_rx_dv.
   logic       er;      // registered gmii_rx_er.
   logic [7:0] data;    // registered gmii_rxd.
   logic       start;   // first dest byte is on data.

   modport src (
      output dv,
      output er,
      output data
   );

   modport ctrl (
      input  dv,
      input  er,
      input  data,
      output start
   );

   modport sink (
      input dv,
      input er,
      input data,
      input start
   );

endinterface

`default_nettype wire

// ==== source/gmii_rx_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module gmii_rx_pipe (
   input  wire        rx_clk,
   input  wire        reset,
   input  wire        gmii_rx_dv,
   input  wire        gmii_rx_er,
   input  wire  [7:0] gmii_rxd,
   rx_byte_if.src     rx,
   output logic [7:0] del_data,
   output logic       del_dv
);

   logic [gemac_rx_pkg::RX_DELAY-1:0] dv_sr;
   logic [7:0]                        data_sr [gemac_rx_pkg::RX_DELAY];

   always_ff @(posedge rx_clk)
   begin
      if (reset)
      begin
         rx.dv <= 1'b0;
         dv_sr <= '0;
      end
      else
      begin
         rx.dv <= gmii_rx_dv;
         dv_sr <= {dv_sr[gemac_rx_pkg::RX_DELAY-2:0], rx.dv};
      end
   end

   // payload stages.
   always_ff @(posedge rx_clk)
   begin
      rx.er      <= gmii_rx_er;
      rx.data    <= gmii_rxd;
      data_sr[0] <= rx.data;
      for (int i = 1; i < gemac_rx_pkg::RX_DELAY; i++)
         data_sr[i] <= data_sr[i-1];
   end

   assign del_data = data_sr[gemac_rx_pkg::RX_DELAY-1];
   assign del_dv   = dv_sr[gemac_rx_pkg::RX_DELAY-1];

endmodule

`default_nettype wire

// ==== source/dest_addr_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module dest_addr_classifier (
   input  wire         rx_clk,
   input  wire         reset,
   rx_byte_if.sink     rx,
   input  wire  [47:0] ucast_addr,
   input  wire  [47:0] mcast_addr,
   output logic        is_ucast,
   output logic        is_mcast,
   output logic        is_bcast,
   output logic        is_pause,
   output logic        addr_done
);

   logic [47:0] addr_q;
   logic [2:0]  byte_cnt;   // nonzero while collecting.

   always_ff @(posedge rx_clk)
   begin
      if (reset)
      begin
         byte_cnt  <= 3'd0;
         addr_done <= 1'b0;
      end
      else if (rx.start)
      begin
         byte_cnt  <= 3'd1;
         addr_done <= 1'b0;
      end
      else if (byte_cnt != 3'd0)
      begin
         if (!rx.dv)
            byte_cnt <= 3'd0;   // runt, give up.
         else if (byte_cnt == 3'd5)
         begin
            byte_cnt  <= 3'd0;
            addr_done <= 1'b1;
         end
         else
            byte_cnt <= byte_cnt + 3'd1;
      end
   end

   // first byte on the wire ends up in the top octet.
   always_ff @(posedge rx_clk)
   begin
      if (rx.start || byte_cnt != 3'd0)
         addr_q <= {addr_q[39:0], rx.data};
   end

   assign is_ucast = addr_done && (addr_q == ucast_addr);
   assign is_mcast = addr_done && (addr_q == mcast_addr);
   assign is_bcast = addr_done && (addr_q == gemac_rx_pkg::BCAST_ADDR);
   assign is_pause = addr_done && (addr_q == gemac_rx_pkg::PAUSE_ADDR);

   a_done_after_start : assert property (@(posedge rx_clk) disable iff (reset)
      $rose(addr_done) |-> $past(rx.start, 6));

endmodule

`default_nettype wire

// ==== source/crc32_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc32_check (
   input  wire     rx_clk,
   input  wire     reset,
   rx_byte_if.sink rx,
   output logic    crc_match
);

   logic [31:0] crc_q;
   logic [31:0] crc_rev;

   // one byte, lsb first.
   function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] d);
      logic [31:0] c;
      c = crc ^ {24'h0, d};
      for (int i = 0; i < 8; i++)
      begin
         if (c[0])
            c = (c >> 1) ^ gemac_rx_pkg::CRC_POLY;
         else
            c = c >> 1;
      end
      return c;
   endfunction

   always_ff @(posedge rx_clk)
   begin
      if (reset)
         crc_q <= 32'hFFFF_FFFF;
      else if (rx.start)
         crc_q <= crc_byte(32'hFFFF_FFFF, rx.data);   // preset folded in.
      else if (rx.dv && !rx.er)
         crc_q <= crc_byte(crc_q, rx.data);
   end

   // the residue constant is in msb-first order, so flip the register.
   assign crc_rev   = {<<{crc_q}};
   assign crc_match = (crc_rev == gemac_rx_pkg::CRC_RESIDUE);

endmodule

`default_nettype wire

// ==== source/gemac_rx_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module gemac_rx_ctrl (
   input  wire         rx_clk,
   input  wire         reset,
   rx_byte_if.ctrl     rx,
   input  wire         del_dv,
   input  wire         is_ucast,
   input  wire         is_mcast,
   input  wire         is_bcast,
   input  wire         is_pause,
   input  wire         addr_done,
   input  wire         crc_match,
   input  wire         pass_ucast,
   input  wire         pass_mcast,
   input  wire         pass_bcast,
   input  wire         pass_pause,
   input  wire         pass_all,
   output logic        rx_valid,
   output logic        rx_ack,
   output logic        rx_error,
   output logic        pause_rcvd,
   output logic [15:0] pause_quanta_rcvd
);

   gemac_rx_pkg::rx_state_t rx_state;
   gemac_rx_pkg::rx_state_t end_state;

   logic [15:0] byte_cnt;   // dest byte 0 is count 0.
   logic [15:0] quanta_q;
   logic        sfd_seen;
   logic        addr_hit;
   logic        keep;
   logic        kept;
   logic        status_ready;
   logic        frame_ok;
   logic        status_fire;
   logic        pause_ok;

   assign sfd_seen = (rx_state == gemac_rx_pkg::RX_PREAMBLE) && rx.dv && !rx.er &&
                     (rx.data == gemac_rx_pkg::SFD_BYTE);
   // flags from the previous frame are still up on the start cycle.
   assign addr_hit = (rx_state == gemac_rx_pkg::RX_ADDR) && rx.dv && !rx.er &&
                     addr_done && !rx.start;
   assign keep = (pass_ucast && is_ucast) || (pass_mcast && is_mcast) ||
                 (pass_bcast && is_bcast) || (pass_pause && is_pause) || pass_all;
   assign end_state = crc_match ? gemac_rx_pkg::RX_GOODFRAME : gemac_rx_pkg::RX_ERROR;
   assign pause_ok = (rx_state == gemac_rx_pkg::RX_PAUSE_WAIT_CRC) && !rx.dv && crc_match &&
                     (byte_cnt >= gemac_rx_pkg::MIN_FRAME_LEN);
   assign status_fire = kept && !del_dv && status_ready;   // delayed frame has drained.

   always_ff @(posedge rx_clk)
   begin
      if (reset)
         rx.start <= 1'b0;
      else
         rx.start <= sfd_seen;
   end

   always_ff @(posedge rx_clk)
   begin
      if (reset || sfd_seen)
         byte_cnt <= 16'd0;
      else if (byte_cnt != 16'hFFFF)
         byte_cnt <= byte_cnt + 16'd1;
   end

   always_ff @(posedge rx_clk)
   begin
      if (reset)
         rx_state <= gemac_rx_pkg::RX_IDLE;
      else if (rx.dv && rx.er)
         rx_state <= gemac_rx_pkg::RX_ERROR;
      else
         case (rx_state)
            gemac_rx_pkg::RX_IDLE:
               if (rx.dv)
                  rx_state <= (rx.data == gemac_rx_pkg::PREAMBLE_BYTE) ?
                              gemac_rx_pkg::RX_PREAMBLE : gemac_rx_pkg::RX_DROP;
            gemac_rx_pkg::RX_PREAMBLE:
               if (!rx.dv)
                  rx_state <= gemac_rx_pkg::RX_IDLE;
               else if (rx.data == gemac_rx_pkg::SFD_BYTE)
                  rx_state <= gemac_rx_pkg::RX_ADDR;
               else if (rx.data != gemac_rx_pkg::PREAMBLE_BYTE)
                  rx_state <= gemac_rx_pkg::RX_DROP;
            gemac_rx_pkg::RX_ADDR:
               if (!rx.dv)
                  rx_state <= gemac_rx_pkg::RX_ERROR;   // runt.
               else if (addr_hit)
                  rx_state <= is_pause ? gemac_rx_pkg::RX_PAUSE_TYPE : gemac_rx_pkg::RX_FRAME;
            gemac_rx_pkg::RX_FRAME, gemac_rx_pkg::RX_DROP:
               if (!rx.dv)
                  rx_state <= end_state;
            gemac_rx_pkg::RX_PAUSE_TYPE:
               if (!rx.dv)
                  rx_state <= end_state;
               else if (byte_cnt == 16'd12 && rx.data != gemac_rx_pkg::PAUSE_TYPE[15:8])
                  rx_state <= gemac_rx_pkg::RX_DROP;
               else if (byte_cnt == 16'd13)
                  rx_state <= (rx.data == gemac_rx_pkg::PAUSE_TYPE[7:0]) ?
                              gemac_rx_pkg::RX_PAUSE_OPCODE : gemac_rx_pkg::RX_DROP;
            gemac_rx_pkg::RX_PAUSE_OPCODE:
               if (!rx.dv)
                  rx_state <= end_state;
               else if (byte_cnt == 16'd14 && rx.data != gemac_rx_pkg::PAUSE_OPCODE[15:8])
                  rx_state <= gemac_rx_pkg::RX_DROP;
               else if (byte_cnt == 16'd15)
                  rx_state <= (rx.data == gemac_rx_pkg::PAUSE_OPCODE[7:0]) ?
                              gemac_rx_pkg::RX_PAUSE_QUANTA : gemac_rx_pkg::RX_DROP;
            gemac_rx_pkg::RX_PAUSE_QUANTA:
               if (!rx.dv)
                  rx_state <= end_state;
               else if (byte_cnt == 16'd17)
                  rx_state <= gemac_rx_pkg::RX_PAUSE_WAIT_CRC;
            gemac_rx_pkg::RX_PAUSE_WAIT_CRC:
               if (!rx.dv)
                  rx_state <= pause_ok ? gemac_rx_pkg::RX_DO_PAUSE : end_state;
            gemac_rx_pkg::RX_ERROR:
               if (!rx.dv)
                  rx_state <= gemac_rx_pkg::RX_IDLE;
            default:
               rx_state <= gemac_rx_pkg::RX_IDLE;   // goodframe, do_pause.
         endcase
   end

   // quanta msb arrives first.
   always_ff @(posedge rx_clk)
   begin
      if (rx_state == gemac_rx_pkg::RX_PAUSE_QUANTA && rx.dv)
      begin
         if (byte_cnt == 16'd16)
            quanta_q[15:8] <= rx.data;
         else if (byte_cnt == 16'd17)
            quanta_q[7:0] <= rx.data;
      end
   end

   always_ff @(posedge rx_clk)
   begin
      if (reset)
         pause_quanta_rcvd <= 16'd0;
      else if (pause_ok)
         pause_quanta_rcvd <= quanta_q;
   end

   assign pause_rcvd = (rx_state == gemac_rx_pkg::RX_DO_PAUSE);

   always_ff @(posedge rx_clk)
   begin
      if (reset)
         kept <= 1'b0;
      else if (addr_hit)
         kept <= keep;
      else if (status_fire)
         kept <= 1'b0;
   end

   always_ff @(posedge rx_clk)
   begin
      if (reset || rx.start || status_fire)
         status_ready <= 1'b0;
      else if (rx_state == gemac_rx_pkg::RX_GOODFRAME || rx_state == gemac_rx_pkg::RX_DO_PAUSE)
         status_ready <= 1'b1;
      else if (rx_state == gemac_rx_pkg::RX_ERROR && !rx.dv)
         status_ready <= 1'b1;
   end

   always_ff @(posedge rx_clk)
   begin
      if (rx_state == gemac_rx_pkg::RX_GOODFRAME || rx_state == gemac_rx_pkg::RX_DO_PAUSE)
         frame_ok <= 1'b1;
      else if (rx_state == gemac_rx_pkg::RX_ERROR && !rx.dv)
         frame_ok <= 1'b0;
   end

   always_ff @(posedge rx_clk)
   begin
      if (reset)
      begin
         rx_ack   <= 1'b0;
         rx_error <= 1'b0;
      end
      else
      begin
         rx_ack   <= status_fire && frame_ok;
         rx_error <= status_fire && !frame_ok;
      end
   end

   assign rx_valid = kept && del_dv;

   a_status_excl : assert property (@(posedge rx_clk) disable iff (reset)
      !(rx_ack && rx_error));
   a_pause_pulse : assert property (@(posedge rx_clk) disable iff (reset)
      pause_rcvd |=> !pause_rcvd);
   a_status_after_valid : assert property (@(posedge rx_clk) disable iff (reset)
      $fell(rx_valid) |-> ##[1:4] (rx_ack || rx_error));

endmodule

`default_nettype wire

// ==== source/gemac_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module gemac_rx (
   input  wire         rx_clk,
   input  wire         reset,
   input  wire         gmii_rx_dv,
   input  wire         gmii_rx_er,
   input  wire  [7:0]  gmii_rxd,
   input  wire  [47:0] ucast_addr,
   input  wire  [47:0] mcast_addr,
   input  wire         pass_ucast,
   input  wire         pass_mcast,
   input  wire         pass_bcast,
   input  wire         pass_pause,
   input  wire         pass_all,
   output wire  [7:0]  rx_data,
   output wire         rx_valid,
   output wire         rx_ack,
   output wire         rx_error,
   output wire  [15:0] pause_quanta_rcvd,
   output wire         pause_rcvd
);

   wire del_dv;
   wire is_ucast;
   wire is_mcast;
   wire is_bcast;
   wire is_pause;
   wire addr_done;
   wire crc_match;

   rx_byte_if rx_bus ();

   gmii_rx_pipe pipe (
      .rx_clk     (rx_clk),
      .reset      (reset),
      .gmii_rx_dv (gmii_rx_dv),
      .gmii_rx_er (gmii_rx_er),
      .gmii_rxd   (gmii_rxd),
      .rx         (rx_bus.src),
      .del_data   (rx_data),   // straight out to the user.
      .del_dv     (del_dv)
   );

   dest_addr_classifier classifier (
      .rx_clk     (rx_clk),
      .reset      (reset),
      .rx         (rx_bus.sink),
      .ucast_addr (ucast_addr),
      .mcast_addr (mcast_addr),
      .is_ucast   (is_ucast),
      .is_mcast   (is_mcast),
      .is_bcast   (is_bcast),
      .is_pause   (is_pause),
      .addr_done  (addr_done)
   );

   crc32_check crc (
      .rx_clk    (rx_clk),
      .reset     (reset),
      .rx        (rx_bus.sink),
      .crc_match (crc_match)
   );

   gemac_rx_ctrl ctrl (
      .rx_clk            (rx_clk),
      .reset             (reset),
      .rx                (rx_bus.ctrl),
      .del_dv            (del_dv),
      .is_ucast          (is_ucast),
      .is_mcast          (is_mcast),
      .is_bcast          (is_bcast),
      .is_pause          (is_pause),
      .addr_done         (addr_done),
      .crc_match         (crc_match),
      .pass_ucast        (pass_ucast),
      .pass_mcast        (pass_mcast),
      .pass_bcast        (pass_bcast),
      .pass_pause        (pass_pause),
      .pass_all          (pass_all),
      .rx_valid          (rx_valid),
      .rx_ack            (rx_ack),
      .rx_error          (rx_error),
      .pause_rcvd        (pause_rcvd),
      .pause_quanta_rcvd (pause_quanta_rcvd)
   );

endmodule

`default_nettype wire

// ==== tb/rx_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_checker (
   input wire        rx_clk,
   input wire        reset,
   input wire  [7:0] rx_data,
   input wire        rx_valid,
   input wire        rx_ack,
   input wire        rx_error,
   input wire        pause_rcvd,
   input wire [15:0] pause_quanta_rcvd
);

   logic [7:0]  exp_bytes [$];   // kept frames, back to back.
   int          exp_len [$];
   logic        exp_good [$];
   logic [15:0] exp_quanta [$];
   logic [7:0]  got [$];
   logic [15:0] last_quanta;
   logic [15:0] quanta_exp;
   int          errors = 0;

   task automatic expect_frame(input logic [7:0] q [$], input logic good);
      foreach (q[i])
         exp_bytes.push_back(q[i]);
      exp_len.push_back(q.size());
      exp_good.push_back(good);
   endtask

   task automatic expect_pause(input logic [15:0] quanta);
      exp_quanta.push_back(quanta);
   endtask

   function automatic int pending();
      return exp_len.size() + exp_quanta.size();
   endfunction

   task automatic close_frame();
      int         n;
      logic       good;
      logic [7:0] b;
      n    = exp_len.pop_front();
      good = exp_good.pop_front();
      if (got.size() != n)
      begin
         $display("ERROR rx_valid byte count exp %h got %h", n, got.size());
         errors++;
      end
      for (int i = 0; i < n; i++)
      begin
         b = exp_bytes.pop_front();
         if (i < got.size() && got[i] !== b)
         begin
            $display("ERROR rx_data byte %0d exp %h got %h", i, b, got[i]);
            errors++;
         end
      end
      if (rx_ack !== good)
      begin
         $display("ERROR rx_ack exp %h got %h", good, rx_ack);
         errors++;
      end
      if (rx_error !== !good)
      begin
         $display("ERROR rx_error exp %h got %h", !good, rx_error);
         errors++;
      end
      got.delete();
   endtask

   // outputs are registered, so the falling edge sees settled values.
   always @(negedge rx_clk)
   begin
      if (reset === 1'b0)
      begin
         if (rx_valid)
         begin
            if (got.size() == 0 && exp_len.size() == 0)
            begin
               $display("frame data came out on rx_data although no frame should pass");
               errors++;
            end
            got.push_back(rx_data);
         end
         if (rx_ack || rx_error)
         begin
            if (exp_len.size() == 0)
            begin
               $display("status pulse came with no delivered frame outstanding");
               errors++;
               got.delete();
            end
            else
               close_frame();
         end
         if (pause_rcvd)
         begin
            if (exp_quanta.size() == 0)
            begin
               $display("pause_rcvd pulsed for a frame that is not a valid pause frame");
               errors++;
            end
            else
            begin
               quanta_exp = exp_quanta.pop_front();
               if (pause_quanta_rcvd !== quanta_exp)
               begin
                  $display("ERROR pause_quanta_rcvd exp %h got %h", quanta_exp,
                           pause_quanta_rcvd);
                  errors++;
               end
            end
         end
         else if (pause_quanta_rcvd !== last_quanta)
         begin
            $display("ERROR pause_quanta_rcvd exp %h got %h", last_quanta, pause_quanta_rcvd);
            errors++;
         end
      end
      last_quanta = pause_quanta_rcvd;
   end

endmodule

`default_nettype wire

// ==== tb/tb_gemac_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gemac_rx;

   logic        rx_clk;
   logic        reset;
   logic        gmii_rx_dv;
   logic        gmii_rx_er;
   logic [7:0]  gmii_rxd;
   logic [47:0] ucast_addr;
   logic [47:0] mcast_addr;
   logic        pass_ucast;
   logic        pass_mcast;
   logic        pass_bcast;
   logic        pass_pause;
   logic        pass_all;
   wire  [7:0]  rx_data;
   wire         rx_valid;
   wire         rx_ack;
   wire         rx_error;
   wire  [15:0] pause_quanta_rcvd;
   wire         pause_rcvd;

   logic [31:0] lcg_state;
   logic [7:0]  frm [$];   // dest through fcs.
   logic        fcs_bad;
   logic [15:0] quanta;
   int          n_tests = 0;
   int          tests_failed = 0;
   int          errs_before = 0;

   gemac_rx UUT (.*);

   rx_checker chk (.*);

   initial
   begin
      rx_clk = 1'b0;
      forever #50 rx_clk = ~rx_clk;
   end

   function automatic logic [7:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:24];
   endfunction

   // bit-serial, lsb first.
   function automatic logic [31:0] crc32_ref(input logic [7:0] q [$]);
      logic [31:0] c;
      logic        fb;
      c = 32'hFFFF_FFFF;
      foreach (q[i])
         for (int b = 0; b < 8; b++)
         begin
            fb = c[0] ^ q[i][b];
            c  = c >> 1;
            if (fb)
               c = c ^ gemac_rx_pkg::CRC_POLY;
         end
      return ~c;
   endfunction

   function automatic logic expect_keep(input logic [47:0] dest);
      return pass_all || (pass_ucast && dest == ucast_addr) ||
             (pass_mcast && dest == mcast_addr) ||
             (pass_bcast && dest == gemac_rx_pkg::BCAST_ADDR) ||
             (pass_pause && dest == gemac_rx_pkg::PAUSE_ADDR);
   endfunction

   function automatic logic expect_pause(input logic crc_good);
      return crc_good && frm.size() >= int'(gemac_rx_pkg::MIN_FRAME_LEN) &&
             {frm[0], frm[1], frm[2], frm[3], frm[4], frm[5]} == gemac_rx_pkg::PAUSE_ADDR &&
             {frm[12], frm[13]} == gemac_rx_pkg::PAUSE_TYPE &&
             {frm[14], frm[15]} == gemac_rx_pkg::PAUSE_OPCODE;
   endfunction

   task automatic build_frame(input logic [47:0] dest, input logic [15:0] etype,
                              input int plen);
      frm.delete();
      for (int i = 5; i >= 0; i--)
         frm.push_back(dest[i*8 +: 8]);
      for (int i = 0; i < 6; i++)
         frm.push_back(next_rand());   // source address.
      frm.push_back(etype[15:8]);
      frm.push_back(etype[7:0]);
      for (int i = 0; i < plen; i++)
         frm.push_back(next_rand());
   endtask

   task automatic add_fcs(input logic bad);
      logic [31:0] crc;
      crc = crc32_ref(frm);
      for (int i = 0; i < 4; i++)
         frm.push_back(crc[i*8 +: 8]);   // low byte goes first.
      if (bad)
         frm[frm.size() - 2] = frm[frm.size() - 2] ^ 8'h5A;
      fcs_bad = bad;
   endtask

   task automatic data_frame(input logic [47:0] dest, input logic bad);
      build_frame(dest, 16'h0800, 46);
      add_fcs(bad);
   endtask

   task automatic pause_frame(input logic [15:0] opcode, input int plen, input logic bad);
      quanta = {next_rand(), next_rand()};
      build_frame(gemac_rx_pkg::PAUSE_ADDR, gemac_rx_pkg::PAUSE_TYPE, plen);
      frm[14] = opcode[15:8];
      frm[15] = opcode[7:0];
      frm[16] = quanta[15:8];
      frm[17] = quanta[7:0];
      add_fcs(bad);
   endtask

   task automatic set_pass(input logic u, input logic m, input logic b, input logic p,
                           input logic a);
      @(posedge rx_clk);
      pass_ucast <= u;
      pass_mcast <= m;
      pass_bcast <= b;
      pass_pause <= p;
      pass_all   <= a;
   endtask

   task automatic send_frame(input logic [7:0] first_byte, input int er_at);
      logic [47:0] dest;
      logic        good_pre;
      @(posedge rx_clk);
      dest     = {frm[0], frm[1], frm[2], frm[3], frm[4], frm[5]};
      good_pre = (first_byte == gemac_rx_pkg::PREAMBLE_BYTE);
      if (good_pre && expect_keep(dest))
         chk.expect_frame(frm, !fcs_bad && er_at < 0);
      if (good_pre && er_at < 0 && expect_pause(!fcs_bad))
         chk.expect_pause({frm[16], frm[17]});
      for (int i = 0; i < 8; i++)
      begin
         gmii_rx_dv <= 1'b1;
         gmii_rxd   <= (i == 0) ? first_byte :
                       ((i == 7) ? gemac_rx_pkg::SFD_BYTE : gemac_rx_pkg::PREAMBLE_BYTE);
         @(posedge rx_clk);
      end
      foreach (frm[i])
      begin
         gmii_rxd   <= frm[i];
         gmii_rx_er <= (i == er_at);
         @(posedge rx_clk);
      end
      gmii_rx_dv <= 1'b0;
      gmii_rx_er <= 1'b0;
      gmii_rxd   <= 8'h00;
      repeat (12) @(posedge rx_clk);   // inter-frame gap.
   endtask

   task automatic end_test(input string name);
      int t;
      t = 0;
      while (chk.pending() != 0 && t < 20)
      begin
         @(posedge rx_clk);
         t++;
      end
      if (chk.pending() != 0)
      begin
         $display("timeout in %s while waiting for frame status or pause pulse", name);
         $display("*** FAILED ***");
         $finish;
      end
      else
      begin
         n_tests++;
         if (chk.errors != errs_before)
            tests_failed++;
         $display("test %0d %s: %0d errors", n_tests, name, chk.errors - errs_before);
         errs_before = chk.errors;
      end
   endtask

   initial
   begin
      lcg_state  = 32'hc6c5_51dd;
      fcs_bad    = 1'b0;
      reset      <= 1'b1;
      gmii_rx_dv <= 1'b0;
      gmii_rx_er <= 1'b0;
      gmii_rxd   <= 8'h00;
      ucast_addr <= 48'h0010_A4E3_7B21;
      mcast_addr <= 48'h0100_5E00_00FB;
      pass_ucast <= 1'b1;
      pass_mcast <= 1'b0;
      pass_bcast <= 1'b0;
      pass_pause <= 1'b0;
      pass_all   <= 1'b0;
      repeat (4) @(posedge rx_clk);
      reset <= 1'b0;
      repeat (4) @(posedge rx_clk);

      data_frame(48'h0010_A4E3_7B21, 1'b0);
      send_frame(gemac_rx_pkg::PREAMBLE_BYTE, -1);
      end_test("good unicast");

      data_frame(48'h0010_A4E3_7B22, 1'b0);   // nobody's address.
      send_frame(gemac_rx_pkg::PREAMBLE_BYTE, -1);
      data_frame(48'h0100_5E00_00FB, 1'b0);
      send_frame(gemac_rx_pkg::PREAMBLE_BYTE, -1);
      data_frame(gemac_rx_pkg::BCAST_ADDR, 1'b0);
      send_frame(gemac_rx_pkg::PREAMBLE_BYTE, -1);
      set_pass(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
      data_frame(48'h0100_5E00_00FB, 1'b0);
      send_frame(gemac_rx_pkg::PREAMBLE_BYTE, -1);
      set_pass(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
      data_frame(gemac_rx_pkg::BCAST_ADDR, 1'b0);
      send_frame(gemac_rx_pkg::PREAMBLE_BYTE, -1);
      set_pass(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
      data_frame(48'h0010_A4E3_7B22, 1'b0);
      send_frame(gemac_rx_pkg::PREAMBLE_BYTE, -1);
      end_test("address filter");

      set_pass(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      data_frame(48'h0010_A4E3_7B21, 1'b1);
      send_frame(gemac_rx_pkg::PREAMBLE_BYTE, -1);
      end_test("bad fcs");

      data_frame(48'h0010_A4E3_7B21, 1'b0);
      send_frame(gemac_rx_pkg::PREAMBLE_BYTE, 20);
      data_frame(48'h0010_A4E3_7B21, 1'b0);
      send_frame(8'h5A, -1);
      data_frame(48'h0010_A4E3_7B21, 1'b0);
      send_frame(gemac_rx_pkg::PREAMBLE_BYTE, -1);
      end_test("gmii error and bad preamble");

      pause_frame(gemac_rx_pkg::PAUSE_OPCODE, 46, 1'b0);
      send_frame(gemac_rx_pkg::PREAMBLE_BYTE, -1);
      set_pass(1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
      pause_frame(gemac_rx_pkg::PAUSE_OPCODE, 46, 1'b0);
      send_frame(gemac_rx_pkg::PREAMBLE_BYTE, -1);
      end_test("valid pause");

      pause_frame(16'h0002, 46, 1'b0);
      send_frame(gemac_rx_pkg::PREAMBLE_BYTE, -1);
      pause_frame(gemac_rx_pkg::PAUSE_OPCODE, 46, 1'b1);
      send_frame(gemac_rx_pkg::PREAMBLE_BYTE, -1);
      pause_frame(gemac_rx_pkg::PAUSE_OPCODE, 30, 1'b0);   // 48 bytes.
      send_frame(gemac_rx_pkg::PREAMBLE_BYTE, -1);
      end_test("rejected pause");

      $display("%0d tests run, %0d failed, %0d errors", n_tests, tests_failed, chk.errors);
      if (chk.errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/gemac_rx_pkg.sv
source/rx_byte_if.sv
source/gmii_rx_pipe.sv
source/dest_addr_classifier.sv
source/crc32_check.sv
source/gemac_rx_ctrl.sv
source/gemac_rx.sv
tb/rx_checker.sv
tb/tb_gemac_rx.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_gemac_rx
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard source/*.sv tb/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
	   echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
